// File: design/mmu_pkg.sv
package mmu_pkg;

    // ------------------------------------------------------------
    // address widths for sv39
    // ------------------------------------------------------------
    localparam int unsigned VLEN = 39;
    localparam int unsigned PLEN = 56;
    localparam int unsigned PPNW = 44;
    localparam int unsigned VPNW = 27;
    // one vpn field indexes one level of the page table
    localparam int unsigned VPN_FIELD_W = 9;

    typedef logic [VLEN-1:0] vaddr_t;
    typedef logic [PLEN-1:0] paddr_t;
    typedef logic [PPNW-1:0] ppn_t;
    // vpn[2] is the top level, vpn[0] the leaf level
    typedef logic [VPNW/VPN_FIELD_W-1:0][VPN_FIELD_W-1:0] vpn_t;

    // exception causes, only the ones this mmu can raise
    typedef logic [3:0] cause_t;
    localparam cause_t INSTR_ACCESS_FAULT = 4'd1;
    localparam cause_t INSTR_PAGE_FAULT   = 4'd12;
    localparam cause_t LOAD_PAGE_FAULT    = 4'd13;
    localparam cause_t STORE_PAGE_FAULT   = 4'd15;

    typedef logic [1:0] priv_t;
    localparam priv_t PRIV_U = 2'd0;
    localparam priv_t PRIV_S = 2'd1;

    typedef logic [1:0] page_size_t;
    localparam page_size_t PAGE_4K = 2'd0;
    localparam page_size_t PAGE_2M = 2'd1;
    localparam page_size_t PAGE_1G = 2'd2;

    // ------------------------------------------------------------
    // structs shared between the tlbs and the translation paths
    // ------------------------------------------------------------
    typedef struct packed {
        ppn_t ppn;
        logic d;
        logic a;
        logic u;
        logic x;
        logic w;
        logic r;
        logic v;
    } pte_t;

    typedef struct packed {
        logic       valid;
        logic       is_instr;
        vpn_t       vpn;
        page_size_t size;
        pte_t       pte;
    } tlb_refill_t;

    typedef struct packed {
        cause_t cause;
        vaddr_t tval;
        logic   valid;
    } exception_t;

    typedef struct packed {
        logic   req;
        vaddr_t vaddr;
    } fetch_req_t;

    typedef struct packed {
        logic       valid;
        paddr_t     paddr;
        exception_t ex;
    } fetch_rsp_t;

    typedef struct packed {
        logic       hit;
        page_size_t size;
        pte_t       pte;
    } tlb_lookup_t;

endpackage

// File: design/tlb.sv
`timescale 1ns/1ps

module tlb #(
    parameter int unsigned NR_ENTRIES = 4
) (
    input  logic                 clk_i,
    input  logic                 rst_ni,
    input  logic                 flush_i,
    input  mmu_pkg::tlb_refill_t refill_i,
    input  logic                 refill_en_i,
    input  mmu_pkg::vaddr_t      lu_vaddr_i,
    output mmu_pkg::tlb_lookup_t lu_o
);

    localparam int unsigned IDX_W = (NR_ENTRIES > 1) ? $clog2(NR_ENTRIES) : 1;

    // entry storage, only the valid bits are control state
    logic [NR_ENTRIES-1:0] valid_q;
    mmu_pkg::vpn_t         vpn_q  [NR_ENTRIES];
    mmu_pkg::page_size_t   size_q [NR_ENTRIES];
    mmu_pkg::pte_t         pte_q  [NR_ENTRIES];

    logic [IDX_W-1:0]      victim_q;
    logic [NR_ENTRIES-1:0] hit_vec;
    mmu_pkg::vpn_t         lu_vpn;
    logic                  refill_match;
    logic [IDX_W-1:0]      match_idx;
    logic [IDX_W-1:0]      wr_idx;

    // vpn[2] always compared, vpn[1] unless giga page, vpn[0] only for 4k
    function automatic logic vpn_match(input mmu_pkg::vpn_t     va,
                                       input mmu_pkg::vpn_t     tag,
                                       input mmu_pkg::page_size_t size);
        logic m;
        m = (va[2] == tag[2]);
        if (size != mmu_pkg::PAGE_1G) begin
            m = m & (va[1] == tag[1]);
        end
        if (size == mmu_pkg::PAGE_4K) begin
            m = m & (va[0] == tag[0]);
        end
        return m;
    endfunction

    assign lu_vpn = lu_vaddr_i[mmu_pkg::VLEN-1:12];

    // ------------------------------------------------------------
    // lookup
    // ------------------------------------------------------------
    always_comb begin : lookup
        hit_vec = '0;
        lu_o    = '0;
        for (int unsigned i = 0; i < NR_ENTRIES; i++) begin
            if (valid_q[i] && vpn_match(lu_vpn, vpn_q[i], size_q[i])) begin
                hit_vec[i]  = 1'b1;
                lu_o.hit    = 1'b1;
                lu_o.size   = size_q[i];
                lu_o.pte    = pte_q[i];
            end
        end
    end

    // a refill for a page already held overwrites that slot
    // so the same page never sits in two entries
    always_comb begin : refill_slot
        refill_match = 1'b0;
        match_idx    = '0;
        for (int unsigned i = 0; i < NR_ENTRIES; i++) begin
            if (valid_q[i] && vpn_match(refill_i.vpn, vpn_q[i], size_q[i])) begin
                refill_match = 1'b1;
                match_idx    = IDX_W'(i);
            end
        end
        wr_idx = refill_match ? match_idx : victim_q;
    end

    // ------------------------------------------------------------
    // valid bits and round-robin pointer
    // ------------------------------------------------------------
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            valid_q  <= '0;
            victim_q <= '0;
        end else if (flush_i) begin
            // flush wins over a refill in the same cycle
            valid_q <= '0;
        end else if (refill_en_i) begin
            valid_q[wr_idx] <= 1'b1;
            if (!refill_match) begin
                if (victim_q == IDX_W'(NR_ENTRIES - 1)) begin
                    victim_q <= '0;
                end else begin
                    victim_q <= victim_q + 1'b1;
                end
            end
        end
    end

    // tag and pte payload
    always_ff @(posedge clk_i) begin
        if (refill_en_i && !flush_i) begin
            vpn_q[wr_idx]  <= refill_i.vpn;
            size_q[wr_idx] <= refill_i.size;
            pte_q[wr_idx]  <= refill_i.pte;
        end
    end

    a_single_hit: assert property (@(posedge clk_i) disable iff (!rst_ni) $onehot0(hit_vec))
        else $error("tlb: more than one entry hits");

endmodule

// File: design/itlb_xlate.sv
`timescale 1ns/1ps

module itlb_xlate (
    input  logic                 enable_i,
    input  mmu_pkg::priv_t       priv_i,
    input  mmu_pkg::fetch_req_t  fetch_i,
    input  mmu_pkg::tlb_lookup_t lu_i,
    output mmu_pkg::fetch_rsp_t  fetch_o,
    output logic                 miss_o
);

    mmu_pkg::paddr_t xlate_paddr;
    logic            priv_err;
    logic            non_canonical;

    // u-mode may only fetch from u pages, s-mode never from u pages
    assign priv_err = ((priv_i == mmu_pkg::PRIV_U) && !lu_i.pte.u) ||
                      ((priv_i == mmu_pkg::PRIV_S) &&  lu_i.pte.u);

    // no sign-extension bits reach this port, the top bit alone
    // marks the part of the space that is not reachable
    assign non_canonical = fetch_i.vaddr[mmu_pkg::VLEN-1];

    // page composition from the tlb entry
    always_comb begin : compose
        xlate_paddr = {lu_i.pte.ppn, fetch_i.vaddr[11:0]};
        if (lu_i.size == mmu_pkg::PAGE_2M) begin
            xlate_paddr[20:12] = fetch_i.vaddr[20:12];
        end
        if (lu_i.size == mmu_pkg::PAGE_1G) begin
            xlate_paddr[29:12] = fetch_i.vaddr[29:12];
        end
    end

    always_comb begin : fetch_path
        // bare mode default passes addresses through
        fetch_o.valid = fetch_i.req;
        fetch_o.paddr = mmu_pkg::paddr_t'(fetch_i.vaddr);
        fetch_o.ex    = '0;
        miss_o        = 1'b0;
        if (enable_i) begin
            fetch_o.valid = 1'b0;
            fetch_o.paddr = xlate_paddr;
            // access fault answers without waiting for a hit
            if (fetch_i.req && non_canonical) begin
                fetch_o.valid = 1'b1;
                fetch_o.ex    = '{cause: mmu_pkg::INSTR_ACCESS_FAULT,
                                  tval:  fetch_i.vaddr,
                                  valid: 1'b1};
            end
            if (lu_i.hit) begin
                fetch_o.valid = fetch_i.req;
                if (fetch_i.req && priv_err) begin
                    fetch_o.ex = '{cause: mmu_pkg::INSTR_PAGE_FAULT,
                                   tval:  fetch_i.vaddr,
                                   valid: 1'b1};
                end
            end else begin
                // miss strobe for the perf counter
                miss_o = fetch_i.req;
            end
        end
        // a response never shows up without its request
        assert (!fetch_o.valid || fetch_i.req)
            else $error("itlb_xlate: fetch valid without request");
    end

endmodule

// File: design/dtlb_xlate.sv
`timescale 1ns/1ps

module dtlb_xlate (
    input  logic                 clk_i,
    input  logic                 rst_ni,
    input  logic                 enable_i,
    input  logic                 sum_i,
    input  logic                 lsu_req_i,
    input  logic                 lsu_is_store_i,
    input  mmu_pkg::priv_t       ld_st_priv_i,
    input  mmu_pkg::vaddr_t      lsu_vaddr_i,
    input  mmu_pkg::exception_t  misaligned_ex_i,
    input  mmu_pkg::tlb_lookup_t lu_i,
    output logic                 lsu_dtlb_hit_o,
    output mmu_pkg::ppn_t        lsu_dtlb_ppn_o,
    output logic                 lsu_valid_o,
    output mmu_pkg::paddr_t      lsu_paddr_o,
    output mmu_pkg::exception_t  lsu_exception_o,
    output logic                 miss_o
);

    // request stage, control part
    logic                 req_q;
    mmu_pkg::exception_t  ex_d;
    mmu_pkg::exception_t  ex_q;
    // request stage, payload part
    mmu_pkg::vaddr_t      vaddr_q;
    logic                 is_store_q;
    mmu_pkg::tlb_lookup_t lu_q;
    logic                 enable_q;
    logic                 sum_q;
    mmu_pkg::priv_t       priv_q;

    mmu_pkg::paddr_t      xlate_paddr;
    logic                 priv_err;
    logic                 xlate_ok;

    // ------------------------------------------------------------
    // cycle 0
    // ------------------------------------------------------------
    // always ready when translation is off
    assign lsu_dtlb_hit_o = enable_i ? lu_i.hit : 1'b1;
    assign miss_o         = lsu_req_i && enable_i && !lu_i.hit;

    always_comb begin : early_ppn
        lsu_dtlb_ppn_o = mmu_pkg::ppn_t'(lsu_vaddr_i[mmu_pkg::VLEN-1:12]);
        if (enable_i) begin
            lsu_dtlb_ppn_o = lu_i.pte.ppn;
            // superpage fields come from the virtual address
            if (lu_i.size == mmu_pkg::PAGE_2M) begin
                lsu_dtlb_ppn_o[8:0] = lsu_vaddr_i[20:12];
            end
            if (lu_i.size == mmu_pkg::PAGE_1G) begin
                lsu_dtlb_ppn_o[17:0] = lsu_vaddr_i[29:12];
            end
        end
    end

    // a stale misaligned flag without request must not raise anything
    always_comb begin : mute_ex
        ex_d       = misaligned_ex_i;
        ex_d.valid = misaligned_ex_i.valid & lsu_req_i;
    end

    // ------------------------------------------------------------
    // register stage
    // ------------------------------------------------------------
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            req_q <= 1'b0;
            ex_q  <= '0;
        end else begin
            req_q <= lsu_req_i;
            ex_q  <= ex_d;
        end
    end

    // mode travels with its request
    always_ff @(posedge clk_i) begin
        vaddr_q    <= lsu_vaddr_i;
        is_store_q <= lsu_is_store_i;
        lu_q       <= lu_i;
        enable_q   <= enable_i;
        sum_q      <= sum_i;
        priv_q     <= ld_st_priv_i;
    end

    // ------------------------------------------------------------
    // cycle 1
    // ------------------------------------------------------------
    // s-mode needs sum for u pages, u-mode needs a u page
    assign priv_err = ((priv_q == mmu_pkg::PRIV_S) && !sum_q && lu_q.pte.u) ||
                      ((priv_q == mmu_pkg::PRIV_U) && !lu_q.pte.u);

    assign xlate_ok = req_q && lu_q.hit;

    always_comb begin : compose
        xlate_paddr = {lu_q.pte.ppn, vaddr_q[11:0]};
        if (lu_q.size == mmu_pkg::PAGE_2M) begin
            xlate_paddr[20:12] = vaddr_q[20:12];
        end
        if (lu_q.size == mmu_pkg::PAGE_1G) begin
            xlate_paddr[29:12] = vaddr_q[29:12];
        end
    end

    always_comb begin : late_rsp
        // pass-through, also covers a forwarded misaligned exception
        lsu_valid_o     = req_q;
        lsu_paddr_o     = mmu_pkg::paddr_t'(vaddr_q);
        lsu_exception_o = ex_q;
        if (enable_q && !ex_q.valid) begin
            // a miss leaves valid low, the lsu retries after refill
            lsu_valid_o = xlate_ok;
            lsu_paddr_o = xlate_paddr;
            if (xlate_ok) begin
                if (is_store_q) begin
                    if (!lu_q.pte.w || !lu_q.pte.d || priv_err) begin
                        lsu_exception_o = '{cause: mmu_pkg::STORE_PAGE_FAULT,
                                            tval:  vaddr_q,
                                            valid: 1'b1};
                    end
                end else if (priv_err) begin
                    lsu_exception_o = '{cause: mmu_pkg::LOAD_PAGE_FAULT,
                                        tval:  vaddr_q,
                                        valid: 1'b1};
                end
            end
        end
    end

    a_valid_after_req: assert property (@(posedge clk_i) disable iff (!rst_ni)
        lsu_valid_o |-> $past(lsu_req_i))
        else $error("dtlb_xlate: lsu valid without a request");

endmodule

// File: design/mmu.sv
`timescale 1ns/1ps

module mmu #(
    parameter int unsigned ITLB_ENTRIES = 4,
    parameter int unsigned DTLB_ENTRIES = 4
) (
    input  logic                 clk_i,
    input  logic                 rst_ni,
    input  logic                 enable_translation_i,
    input  logic                 en_ld_st_translation_i,
    input  logic                 flush_tlb_i,
    input  logic                 sum_i,
    input  mmu_pkg::priv_t       priv_lvl_i,
    input  mmu_pkg::priv_t       ld_st_priv_lvl_i,
    // fetch interface
    input  mmu_pkg::fetch_req_t  fetch_i,
    output mmu_pkg::fetch_rsp_t  fetch_o,
    // load/store interface
    input  logic                 lsu_req_i,
    input  mmu_pkg::vaddr_t      lsu_vaddr_i,
    input  logic                 lsu_is_store_i,
    input  mmu_pkg::exception_t  misaligned_ex_i,
    // cycle 0
    output logic                 lsu_dtlb_hit_o,
    output mmu_pkg::ppn_t        lsu_dtlb_ppn_o,
    // cycle 1
    output logic                 lsu_valid_o,
    output mmu_pkg::paddr_t      lsu_paddr_o,
    output mmu_pkg::exception_t  lsu_exception_o,
    // external refill in place of a walker
    input  mmu_pkg::tlb_refill_t refill_i,
    // perf counter strobes
    output logic                 itlb_miss_o,
    output logic                 dtlb_miss_o
);

    mmu_pkg::tlb_lookup_t itlb_lu;
    mmu_pkg::tlb_lookup_t dtlb_lu;
    logic                 itlb_refill_en;
    logic                 dtlb_refill_en;

    // steer the refill by its target
    assign itlb_refill_en = refill_i.valid &  refill_i.is_instr;
    assign dtlb_refill_en = refill_i.valid & ~refill_i.is_instr;

    // ------------------------------------------------------------
    // instruction side
    // ------------------------------------------------------------
    tlb #(
        .NR_ENTRIES  ( ITLB_ENTRIES   )
    ) i_itlb (
        .clk_i       ( clk_i          ),
        .rst_ni      ( rst_ni         ),
        .flush_i     ( flush_tlb_i    ),
        .refill_i    ( refill_i       ),
        .refill_en_i ( itlb_refill_en ),
        .lu_vaddr_i  ( fetch_i.vaddr  ),
        .lu_o        ( itlb_lu        )
    );

    itlb_xlate i_itlb_xlate (
        .enable_i ( enable_translation_i ),
        .priv_i   ( priv_lvl_i           ),
        .fetch_i  ( fetch_i              ),
        .lu_i     ( itlb_lu              ),
        .fetch_o  ( fetch_o              ),
        .miss_o   ( itlb_miss_o          )
    );

    // ------------------------------------------------------------
    // data side
    // ------------------------------------------------------------
    tlb #(
        .NR_ENTRIES  ( DTLB_ENTRIES   )
    ) i_dtlb (
        .clk_i       ( clk_i          ),
        .rst_ni      ( rst_ni         ),
        .flush_i     ( flush_tlb_i    ),
        .refill_i    ( refill_i       ),
        .refill_en_i ( dtlb_refill_en ),
        .lu_vaddr_i  ( lsu_vaddr_i    ),
        .lu_o        ( dtlb_lu        )
    );

    dtlb_xlate i_dtlb_xlate (
        .clk_i           ( clk_i                  ),
        .rst_ni          ( rst_ni                 ),
        .enable_i        ( en_ld_st_translation_i ),
        .sum_i           ( sum_i                  ),
        .lsu_req_i       ( lsu_req_i              ),
        .lsu_is_store_i  ( lsu_is_store_i         ),
        .ld_st_priv_i    ( ld_st_priv_lvl_i       ),
        .lsu_vaddr_i     ( lsu_vaddr_i            ),
        .misaligned_ex_i ( misaligned_ex_i        ),
        .lu_i            ( dtlb_lu                ),
        .lsu_dtlb_hit_o  ( lsu_dtlb_hit_o         ),
        .lsu_dtlb_ppn_o  ( lsu_dtlb_ppn_o         ),
        .lsu_valid_o     ( lsu_valid_o            ),
        .lsu_paddr_o     ( lsu_paddr_o            ),
        .lsu_exception_o ( lsu_exception_o        ),
        .miss_o          ( dtlb_miss_o            )
    );

endmodule

// File: verification/mmu_tb_table.svh
`ifndef MMU_TB_TABLE_SVH
`define MMU_TB_TABLE_SVH

// row operations
localparam logic [2:0] REFILL = 3'd0;
localparam logic [2:0] FETCH  = 3'd1;
localparam logic [2:0] LOAD   = 3'd2;
localparam logic [2:0] STORE  = 3'd3;
localparam logic [2:0] FLUSH  = 3'd4;

// short names for the table columns
localparam mmu_pkg::priv_t     U     = mmu_pkg::PRIV_U;
localparam mmu_pkg::priv_t     S     = mmu_pkg::PRIV_S;
localparam mmu_pkg::page_size_t SZ_4K = mmu_pkg::PAGE_4K;
localparam mmu_pkg::page_size_t SZ_2M = mmu_pkg::PAGE_2M;
localparam mmu_pkg::page_size_t SZ_1G = mmu_pkg::PAGE_1G;

// pte flags as {d, a, u, x, w, r, v}
localparam logic [6:0] NONE  = 7'b0000000;
localparam logic [6:0] SRWXD = 7'b1101111;
localparam logic [6:0] URWXD = 7'b1111111;
// read and execute only, never written
localparam logic [6:0] SRX   = 7'b0101011;
// writable but still clean
localparam logic [6:0] SRWND = 7'b0100111;

typedef struct packed {
    logic xlate;
    logic sum;
    logic instr;
    logic mis;
} mode_t;

typedef struct packed {
    logic valid;
    logic miss;
} want_t;

typedef struct packed {
    logic [2:0]          op;
    mode_t               mode;
    mmu_pkg::priv_t      priv;
    logic [26:0]         vpn;
    mmu_pkg::page_size_t size;
    logic [19:0]         ppn;
    logic [6:0]          flags;
    want_t               want;
    mmu_pkg::cause_t     cause;
} row_t;

localparam int NUM_ROWS = 41;

// mode is {xlate, sum, instr, mis}, want is {valid, miss}
// vpn is vaddr[38:12], the page offset is drawn at random
// size and ppn on a lookup row give the page it should land in
localparam row_t ROWS [NUM_ROWS] = '{
    // bare mode
    '{FETCH,  4'b0000, S, 27'h0012345, SZ_4K, 20'h00000, NONE,  2'b10, 4'd0 },
    '{LOAD,   4'b0000, S, 27'h0012345, SZ_4K, 20'h00000, NONE,  2'b10, 4'd0 },
    '{STORE,  4'b0000, U, 27'h0054321, SZ_4K, 20'h00000, NONE,  2'b10, 4'd0 },
    // itlb fill, one page of each size plus a user page
    '{REFILL, 4'b0010, S, 27'h0000201, SZ_4K, 20'h80001, SRWXD, 2'b00, 4'd0 },
    '{REFILL, 4'b0010, S, 27'h0000A00, SZ_2M, 20'h80200, SRWXD, 2'b00, 4'd0 },
    '{REFILL, 4'b0010, S, 27'h0080000, SZ_1G, 20'hC0000, SRWXD, 2'b00, 4'd0 },
    '{REFILL, 4'b0010, S, 27'h0000202, SZ_4K, 20'h90002, URWXD, 2'b00, 4'd0 },
    // dtlb fill with the same pages
    '{REFILL, 4'b0000, S, 27'h0000201, SZ_4K, 20'h80001, SRWXD, 2'b00, 4'd0 },
    '{REFILL, 4'b0000, S, 27'h0000A00, SZ_2M, 20'h80200, SRWXD, 2'b00, 4'd0 },
    '{REFILL, 4'b0000, S, 27'h0080000, SZ_1G, 20'hC0000, SRWXD, 2'b00, 4'd0 },
    '{REFILL, 4'b0000, S, 27'h0000202, SZ_4K, 20'h90002, URWXD, 2'b00, 4'd0 },
    // translation, superpages take the low vpn fields from the address
    '{FETCH,  4'b1000, S, 27'h0000201, SZ_4K, 20'h80001, NONE,  2'b10, 4'd0 },
    '{FETCH,  4'b1000, S, 27'h0000A37, SZ_2M, 20'h80200, NONE,  2'b10, 4'd0 },
    '{FETCH,  4'b1000, S, 27'h0081234, SZ_1G, 20'hC0000, NONE,  2'b10, 4'd0 },
    '{LOAD,   4'b1000, S, 27'h0000201, SZ_4K, 20'h80001, NONE,  2'b10, 4'd0 },
    '{LOAD,   4'b1000, S, 27'h0000BFF, SZ_2M, 20'h80200, NONE,  2'b10, 4'd0 },
    '{LOAD,   4'b1000, S, 27'h008ABCD, SZ_1G, 20'hC0000, NONE,  2'b10, 4'd0 },
    '{STORE,  4'b1000, S, 27'h0000201, SZ_4K, 20'h80001, NONE,  2'b10, 4'd0 },
    // privilege checks, sum only opens u pages to s-mode loads
    '{FETCH,  4'b1000, U, 27'h0000201, SZ_4K, 20'h80001, NONE,  2'b10, 4'd12},
    '{FETCH,  4'b1000, U, 27'h0000202, SZ_4K, 20'h90002, NONE,  2'b10, 4'd0 },
    '{FETCH,  4'b1000, S, 27'h0000202, SZ_4K, 20'h90002, NONE,  2'b10, 4'd12},
    '{LOAD,   4'b1000, S, 27'h0000202, SZ_4K, 20'h90002, NONE,  2'b10, 4'd13},
    '{LOAD,   4'b1100, S, 27'h0000202, SZ_4K, 20'h90002, NONE,  2'b10, 4'd0 },
    '{LOAD,   4'b1000, U, 27'h0000201, SZ_4K, 20'h80001, NONE,  2'b10, 4'd13},
    '{LOAD,   4'b1000, U, 27'h0000202, SZ_4K, 20'h90002, NONE,  2'b10, 4'd0 },
    // store faults, these two refills evict the first two dtlb slots
    '{REFILL, 4'b0000, S, 27'h0000203, SZ_4K, 20'hA0003, SRX,   2'b00, 4'd0 },
    '{REFILL, 4'b0000, S, 27'h0000204, SZ_4K, 20'hB0004, SRWND, 2'b00, 4'd0 },
    '{STORE,  4'b1000, S, 27'h0000203, SZ_4K, 20'hA0003, NONE,  2'b10, 4'd15},
    '{STORE,  4'b1000, S, 27'h0000204, SZ_4K, 20'hB0004, NONE,  2'b10, 4'd15},
    '{LOAD,   4'b1000, S, 27'h0000203, SZ_4K, 20'hA0003, NONE,  2'b10, 4'd0 },
    // forwarded misaligned faults and a non-canonical fetch
    '{LOAD,   4'b1001, S, 27'h0000202, SZ_4K, 20'h90002, NONE,  2'b10, 4'd4 },
    '{STORE,  4'b1001, U, 27'h0000300, SZ_4K, 20'h00000, NONE,  2'b11, 4'd6 },
    '{FETCH,  4'b1000, S, 27'h4000000, SZ_4K, 20'h00000, NONE,  2'b11, 4'd1 },
    // misses, then a flush of pages that hit just before
    '{FETCH,  4'b1000, S, 27'h0000300, SZ_4K, 20'h00000, NONE,  2'b01, 4'd0 },
    '{LOAD,   4'b1000, S, 27'h0000300, SZ_4K, 20'h00000, NONE,  2'b01, 4'd0 },
    '{LOAD,   4'b1000, S, 27'h0000201, SZ_4K, 20'h80001, NONE,  2'b01, 4'd0 },
    '{FETCH,  4'b1000, S, 27'h0000201, SZ_4K, 20'h80001, NONE,  2'b10, 4'd0 },
    '{LOAD,   4'b1000, S, 27'h008ABCD, SZ_1G, 20'hC0000, NONE,  2'b10, 4'd0 },
    '{FLUSH,  4'b0000, S, 27'h0000000, SZ_4K, 20'h00000, NONE,  2'b00, 4'd0 },
    '{FETCH,  4'b1000, S, 27'h0000201, SZ_4K, 20'h80001, NONE,  2'b01, 4'd0 },
    '{LOAD,   4'b1000, S, 27'h008ABCD, SZ_1G, 20'hC0000, NONE,  2'b01, 4'd0 }
};

`endif

// File: verification/mmu_tb.sv
`timescale 1ns/1ps

module mmu_tb;

    localparam int CLK_PERIOD   = 8;
    localparam int RESET_CYCLES = 8;
    // the eviction rows count on four entries per tlb
    localparam int TLB_ENTRIES  = 4;
    // causes the lsu forwards for misaligned accesses
    localparam mmu_pkg::cause_t LD_MISALIGNED = 4'd4;
    localparam mmu_pkg::cause_t ST_MISALIGNED = 4'd6;

    `include "mmu_tb_table.svh"

    logic                 clk_i = 1'b0;
    logic                 rst_ni;
    logic                 enable_translation_i;
    logic                 en_ld_st_translation_i;
    logic                 flush_tlb_i;
    logic                 sum_i;
    mmu_pkg::priv_t       priv_lvl_i;
    mmu_pkg::priv_t       ld_st_priv_lvl_i;
    mmu_pkg::fetch_req_t  fetch_i;
    mmu_pkg::fetch_rsp_t  fetch_o;
    logic                 lsu_req_i;
    mmu_pkg::vaddr_t      lsu_vaddr_i;
    logic                 lsu_is_store_i;
    mmu_pkg::exception_t  misaligned_ex_i;
    logic                 lsu_dtlb_hit_o;
    mmu_pkg::ppn_t        lsu_dtlb_ppn_o;
    logic                 lsu_valid_o;
    mmu_pkg::paddr_t      lsu_paddr_o;
    mmu_pkg::exception_t  lsu_exception_o;
    mmu_pkg::tlb_refill_t refill_i;
    logic                 itlb_miss_o;
    logic                 dtlb_miss_o;

    always #(CLK_PERIOD / 2) clk_i = ~clk_i;

    mmu #(
        .ITLB_ENTRIES ( TLB_ENTRIES ),
        .DTLB_ENTRIES ( TLB_ENTRIES )
    ) uut (
        .clk_i                  ( clk_i                  ),
        .rst_ni                 ( rst_ni                 ),
        .enable_translation_i   ( enable_translation_i   ),
        .en_ld_st_translation_i ( en_ld_st_translation_i ),
        .flush_tlb_i            ( flush_tlb_i            ),
        .sum_i                  ( sum_i                  ),
        .priv_lvl_i             ( priv_lvl_i             ),
        .ld_st_priv_lvl_i       ( ld_st_priv_lvl_i       ),
        .fetch_i                ( fetch_i                ),
        .fetch_o                ( fetch_o                ),
        .lsu_req_i              ( lsu_req_i              ),
        .lsu_vaddr_i            ( lsu_vaddr_i            ),
        .lsu_is_store_i         ( lsu_is_store_i         ),
        .misaligned_ex_i        ( misaligned_ex_i        ),
        .lsu_dtlb_hit_o         ( lsu_dtlb_hit_o         ),
        .lsu_dtlb_ppn_o         ( lsu_dtlb_ppn_o         ),
        .lsu_valid_o            ( lsu_valid_o            ),
        .lsu_paddr_o            ( lsu_paddr_o            ),
        .lsu_exception_o        ( lsu_exception_o        ),
        .refill_i               ( refill_i               ),
        .itlb_miss_o            ( itlb_miss_o            ),
        .dtlb_miss_o            ( dtlb_miss_o            )
    );

    // ------------------------------------------------------------
    // reporting
    // ------------------------------------------------------------
    task automatic stop_on_error(input string msg);
        $display("%s", msg);
        $display("Verification failed");
        $fatal(1, "simulation stopped at the first error");
    endtask

    task automatic check_value(input string name, input logic [63:0] got,
                               input logic [63:0] want);
        assert (got === want)
            else stop_on_error($sformatf("Error: %s is 0x%h, expected 0x%h", name, got, want));
    endtask

    // a zero cause marks a row that must not fault
    task automatic check_response(input string ex_name, input string pa_name,
                                  input mmu_pkg::exception_t ex, input mmu_pkg::paddr_t paddr,
                                  input mmu_pkg::cause_t cause, input mmu_pkg::vaddr_t va,
                                  input mmu_pkg::paddr_t pa);
        check_value({ex_name, ".valid"}, 64'(ex.valid), 64'(cause != 4'd0));
        if (cause != 4'd0) begin
            check_value({ex_name, ".cause"}, 64'(ex.cause), 64'(cause));
            check_value({ex_name, ".tval"}, 64'(ex.tval), 64'(va));
        end else begin
            check_value(pa_name, 64'(paddr), 64'(pa));
        end
    endtask

    // ------------------------------------------------------------
    // expected address from the sv39 page rule
    // ------------------------------------------------------------
    function automatic mmu_pkg::paddr_t expected_paddr(input row_t r, input mmu_pkg::vaddr_t va);
        mmu_pkg::ppn_t ppn;
        ppn = mmu_pkg::ppn_t'(r.ppn);
        // bare mode keeps the virtual address as it is
        if (!r.mode.xlate) begin
            return mmu_pkg::paddr_t'(va);
        end
        case (r.size)
            SZ_2M:   return {ppn[43:9], va[20:0]};
            SZ_1G:   return {ppn[43:18], va[29:0]};
            default: return {ppn, va[11:0]};
        endcase
    endfunction

    task automatic idle_inputs();
        fetch_i         = '0;
        lsu_req_i       = 1'b0;
        lsu_vaddr_i     = '0;
        lsu_is_store_i  = 1'b0;
        misaligned_ex_i = '0;
        refill_i        = '0;
        flush_tlb_i     = 1'b0;
    endtask

    // a row drives its inputs in one cycle and reads the registered lsu answer in the next
    task automatic apply_row(input row_t r);
        mmu_pkg::vaddr_t va;
        mmu_pkg::paddr_t pa;
        va = {r.vpn, 12'($urandom())};
        pa = expected_paddr(r, va);
        @(posedge clk_i);
        #1;
        sum_i            = r.mode.sum;
        priv_lvl_i       = r.priv;
        ld_st_priv_lvl_i = r.priv;
        case (r.op)
            REFILL: begin
                refill_i.valid    = 1'b1;
                refill_i.is_instr = r.mode.instr;
                refill_i.vpn      = r.vpn;
                refill_i.size     = r.size;
                refill_i.pte      = {mmu_pkg::ppn_t'(r.ppn), r.flags};
            end
            FLUSH: begin
                flush_tlb_i = 1'b1;
            end
            FETCH: begin
                enable_translation_i = r.mode.xlate;
                fetch_i.req          = 1'b1;
                fetch_i.vaddr        = va;
            end
            default: begin
                en_ld_st_translation_i = r.mode.xlate;
                lsu_req_i              = 1'b1;
                lsu_vaddr_i            = va;
                lsu_is_store_i         = (r.op == STORE);
                if (r.mode.mis) begin
                    misaligned_ex_i.cause = (r.op == STORE) ? ST_MISALIGNED : LD_MISALIGNED;
                    misaligned_ex_i.tval  = va;
                    misaligned_ex_i.valid = 1'b1;
                end
            end
        endcase
        // combinational answers settle within the cycle
        #1;
        if (r.op == FETCH) begin
            check_value("itlb_miss_o", 64'(itlb_miss_o), 64'(r.want.miss));
            check_value("fetch_o.valid", 64'(fetch_o.valid), 64'(r.want.valid));
            if (r.want.valid) begin
                check_response("fetch_o.ex", "fetch_o.paddr", fetch_o.ex, fetch_o.paddr,
                               r.cause, va, pa);
            end
        end
        if (r.op == LOAD || r.op == STORE) begin
            check_value("dtlb_miss_o", 64'(dtlb_miss_o), 64'(r.want.miss));
            check_value("lsu_dtlb_hit_o", 64'(lsu_dtlb_hit_o), 64'(!r.want.miss));
            if (!r.want.miss) begin
                check_value("lsu_dtlb_ppn_o", 64'(lsu_dtlb_ppn_o), 64'(pa[55:12]));
            end
        end
        @(posedge clk_i);
        #1;
        idle_inputs();
        if (r.op == LOAD || r.op == STORE) begin
            check_value("lsu_valid_o", 64'(lsu_valid_o), 64'(r.want.valid));
            if (r.want.valid) begin
                check_response("lsu_exception_o", "lsu_paddr_o", lsu_exception_o,
                               lsu_paddr_o, r.cause, va, pa);
            end
        end
    endtask

    // ------------------------------------------------------------
    // stimulus and watchdog
    // ------------------------------------------------------------
    initial begin : stimulus
        int unsigned seed_ret;
        seed_ret               = $urandom(32'h2fec9dfd);
        rst_ni                 = 1'b0;
        enable_translation_i   = 1'b0;
        en_ld_st_translation_i = 1'b0;
        sum_i                  = 1'b0;
        priv_lvl_i             = mmu_pkg::PRIV_S;
        ld_st_priv_lvl_i       = mmu_pkg::PRIV_S;
        idle_inputs();
        // a bare request held through reset leaves only the reset to keep lsu valid low
        lsu_req_i              = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk_i);
        #1;
        rst_ni = 1'b1;
        check_value("lsu_valid_o", 64'(lsu_valid_o), 64'd0);
        lsu_req_i = 1'b0;
        for (int i = 0; i < NUM_ROWS; i++) begin
            apply_row(ROWS[i]);
        end
        $display("Verification passed");
        $finish;
    end

    // four cycles per row is twice what a row needs
    initial begin : watchdog
        #((NUM_ROWS * 4 + RESET_CYCLES + 2) * CLK_PERIOD);
        stop_on_error("watchdog expired before all table rows were applied");
    end

endmodule

// File: mmu.f
+incdir+verification
design/mmu_pkg.sv
design/tlb.sv
design/itlb_xlate.sv
design/dtlb_xlate.sv
design/mmu.sv
verification/mmu_tb.sv

// File: Makefile
# Verilator build and run of the mmu testbench

VERILATOR ?= verilator
TOP       ?= mmu_tb
FILELIST  ?= mmu.f
BUILD_DIR ?= build
LOG       ?= sim.log
FAIL_MSG  ?= Verification failed
PASS_MSG  ?= Verification passed
VFLAGS    ?= --binary --assert -j 0

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  help   list these targets"
	@echo "  test   build $(TOP) with verilator, run it and check $(LOG)"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "variables: VERILATOR TOP FILELIST BUILD_DIR LOG VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then \
		echo "simulation reported a failure"; \
		exit 1; \
	fi
	@if ! grep -q "$(PASS_MSG)" $(LOG); then \
		echo "simulation ended without a result"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
